// ==== sim.f ====
source/fscpu_pkg.sv
source/cmd_decode.sv
source/step_table.sv
source/push_motor_ctl.sv
source/req_status.sv
source/fscpu.sv
bench/motor_model.sv
bench/fscpu_tb.sv

// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing -Wno-fatal -j 0
TOP       = fscpu_tb
FILELIST  = sim.f
OBJDIR    = obj_dir
PASS_MSG  = All tests passed!

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the simulation"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)
	./$(OBJDIR)/V$(TOP) | tee /dev/stderr | grep -F '$(PASS_MSG)' > /dev/null

clean:
	rm -rf $(OBJDIR)

// ==== bench/fscpu_tb.sv ====
`default_nettype none

module fscpu_tb;
	import fscpu_pkg::*;

	localparam int ROWS        = 6;
	localparam int TABLE_WORDS = 64;
	localparam int ROW_CYCLES  = 2000;

	typedef struct packed {
		cmd_t         cmd;
		logic [127:0] param;
		img_pos_t     lft_init;
		img_pos_t     rt_init;
		logic         lft_valid;
		logic         rt_valid;
		err_t         exp_err;
		logic [3:0]   exp_lft_moves;
		logic [3:0]   exp_rt_moves;
	} test_row_t;

	logic            clk;
	logic            resetn;
	logic            bpm_init;
	logic            bpm_wr_en;
	step_t           bpm_data;
	wire [IMG_WW:0]  bpm_size;
	logic            req_en;
	cmd_t            req_cmd;
	logic [127:0]    req_param;
	wire             req_done;
	wire err_t       req_err;
	logic            ana_done = 1'b0;
	logic [4:0]      ana_cnt = '0;
	wire             lft_valid;
	wire             rt_valid;
	wire img_pos_t   lft_edge;
	wire img_pos_t   rt_edge;
	wire             ml_start;
	wire             mr_start;
	wire motor_cmd_t ml_cmd;
	wire motor_cmd_t mr_cmd;
	wire             ml_state;
	wire             mr_state;
	logic            edge_load;
	img_pos_t        lft_init_pos;
	img_pos_t        rt_init_pos;
	logic            lft_valid_set;
	logic            rt_valid_set;
	int unsigned     lft_moves = 0;
	int unsigned     rt_moves = 0;
	motor_cmd_t      lft_last;
	motor_cmd_t      rt_last;
	test_row_t       rows [ROWS];

	fscpu dut (
		.clk(clk), .resetn(resetn),
		.bpm_init(bpm_init), .bpm_wr_en(bpm_wr_en), .bpm_data(bpm_data), .bpm_size(bpm_size),
		.req_en(req_en), .req_cmd(req_cmd), .req_param(req_param),
		.req_done(req_done), .req_err(req_err),
		.ana_done(ana_done), .lft_valid(lft_valid), .lft_edge(lft_edge),
		.rt_valid(rt_valid), .rt_edge(rt_edge),
		.ml_start(ml_start), .ml_cmd(ml_cmd), .ml_state(ml_state),
		.mr_start(mr_start), .mr_cmd(mr_cmd), .mr_state(mr_state)
	);

	// left edge grows with dir high, right edge with dir low
	motor_model #(.UP_DIR(1'b1)) lft_motor (
		.clk(clk), .resetn(resetn), .start(ml_start), .cmd(ml_cmd),
		.load(edge_load), .load_pos(lft_init_pos), .valid_set(lft_valid_set),
		.state(ml_state), .edge_pos(lft_edge), .valid(lft_valid)
	);

	motor_model #(.UP_DIR(1'b0)) rt_motor (
		.clk(clk), .resetn(resetn), .start(mr_start), .cmd(mr_cmd),
		.load(edge_load), .load_pos(rt_init_pos), .valid_set(rt_valid_set),
		.state(mr_state), .edge_pos(rt_edge), .valid(rt_valid)
	);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	// image analyser pulse every 32 cycles
	always @(posedge clk) begin
		ana_cnt  <= ana_cnt + 5'd1;
		ana_done <= (ana_cnt == 5'd31);
	end

	always @(posedge clk) begin
		if (ml_start) begin
			lft_moves <= lft_moves + 1;
			lft_last  <= ml_cmd;
		end
		if (mr_start) begin
			rt_moves <= rt_moves + 1;
			rt_last  <= mr_cmd;
		end
	end

	initial begin
		repeat (ROWS * ROW_CYCLES + 4 * TABLE_WORDS) @(posedge clk);
		$display("Test failures found");
		$display("timeout: the run did not finish in the expected number of cycles");
		$fatal(1, "watchdog expired");
	end

	task automatic check_value(input string name, input logic [127:0] got,
			input logic [127:0] exp);
		if (got !== exp) begin
			$display("[FAIL] t=%0t %s: got 0x%0h expected 0x%0h", $time, name, got, exp);
			$display("Test failures found");
			$fatal(1, "value mismatch");
		end
	endtask

	function automatic logic [127:0] make_param(input logic dir_back, input logic dep_img,
			input img_pos_t dst, input img_pos_t tol, input speed_t speed, input step_t step);
		logic [31:0] w0;
		logic [31:0] w1;
		w0 = {29'd0, dep_img, dir_back, 1'b0};
		w1 = {4'd0, tol, 4'd0, dst};
		return {step, speed, w1, w0};
	endfunction

	// move order a motor should get, straight from the command rules
	function automatic motor_cmd_t expected_cmd(input test_row_t row, input logic left);
		motor_cmd_t c;
		img_pos_t   dst;
		img_pos_t   pos;
		dst = row.param[32 +: IMG_WW];
		pos = left ? row.lft_init : row.rt_init;
		c.speed = row.param[95:64];
		if (row.param[2]) begin
			c.step = (dst > pos) ? step_t'(dst - pos) : step_t'(pos - dst);
			// negative error sets dir, mirrored on the left
			c.dir = left ? !(dst < pos) : (dst < pos);
		end else begin
			c.step = row.param[127:96];
			c.dir  = row.param[1];
		end
		return c;
	endfunction

	task automatic check_side(input string side, input test_row_t row, input logic left,
			input int unsigned moved, input motor_cmd_t last);
		motor_cmd_t exp_cmd;
		exp_cmd = expected_cmd(row, left);
		check_value({side, " move count"}, moved, left ? row.exp_lft_moves : row.exp_rt_moves);
		if (moved != 0) begin
			check_value({side, " cmd speed"}, last.speed, exp_cmd.speed);
			check_value({side, " cmd step"}, last.step, exp_cmd.step);
			check_value({side, " cmd dir"}, last.dir, exp_cmd.dir);
		end
	endtask

	task automatic load_table(input int words);
		@(posedge clk);
		bpm_init <= 1'b1;
		for (int k = 0; k < words; k++) begin
			@(posedge clk);
			bpm_wr_en <= 1'b1;
			bpm_data  <= step_t'(k);
		end
		@(posedge clk);
		bpm_wr_en <= 1'b0;
	endtask

	task automatic run_row(input test_row_t row);
		int unsigned lft_before;
		int unsigned rt_before;
		@(posedge clk);
		lft_init_pos  <= row.lft_init;
		rt_init_pos   <= row.rt_init;
		lft_valid_set <= row.lft_valid;
		rt_valid_set  <= row.rt_valid;
		edge_load     <= 1'b1;
		@(posedge clk);
		edge_load <= 1'b0;
		req_en    <= 1'b1;
		req_cmd   <= row.cmd;
		req_param <= row.param;
		lft_before = lft_moves;
		rt_before  = rt_moves;
		@(posedge clk);
		req_en <= 1'b0;
		@(negedge clk);
		while (!req_done)
			@(negedge clk);
		check_value("req_err", req_err, row.exp_err);
		check_side("left", row, 1'b1, lft_moves - lft_before, lft_last);
		check_side("right", row, 1'b0, rt_moves - rt_before, rt_last);
	endtask

	initial begin
		resetn        = 1'b0;
		bpm_init      = 1'b0;
		bpm_wr_en     = 1'b0;
		bpm_data      = '0;
		req_en        = 1'b0;
		req_cmd       = '0;
		req_param     = '0;
		edge_load     = 1'b0;
		lft_init_pos  = '0;
		rt_init_pos   = '0;
		lft_valid_set = 1'b1;
		rt_valid_set  = 1'b1;

		// cmd, param, edges, valid flags, err, left and right moves
		rows[0] = '{CMD_CFG, {96'd0, 32'd4}, 12'd0, 12'd0, 1'b1, 1'b1, 32'd0, 4'd0, 4'd0};
		rows[1] = '{32'd7, 128'd0, 12'd0, 12'd0, 1'b1, 1'b1,
			32'd1 << ERR_BAD_CMD, 4'd0, 4'd0};
		rows[2] = '{CMD_LFT, make_param(1'b1, 1'b0, 12'd0, 12'd0, 32'd500, 32'd77),
			12'd0, 12'd0, 1'b1, 1'b1, 32'd0, 4'd1, 4'd0};
		rows[3] = '{CMD_BOTH, make_param(1'b0, 1'b1, 12'd200, 12'd2, 32'd300, 32'd0),
			12'd150, 12'd260, 1'b1, 1'b1, 32'd0, 4'd1, 4'd1};
		rows[4] = '{CMD_RT, make_param(1'b0, 1'b1, 12'd100, 12'd5, 32'd300, 32'd0),
			12'd0, 12'd103, 1'b1, 1'b1, 32'd0, 4'd0, 4'd0};
		rows[5] = '{CMD_BOTH, make_param(1'b0, 1'b1, 12'd400, 12'd1, 32'd250, 32'd0),
			12'd420, 12'd10, 1'b1, 1'b0, 32'd1 << ERR_NO_EDGE_R, 4'd1, 4'd0};

		repeat (4) @(posedge clk);
		resetn <= 1'b1;

		// identity table, then drop init and load again
		load_table(TABLE_WORDS);
		@(negedge clk);
		check_value("bpm_size", bpm_size, TABLE_WORDS);
		@(posedge clk);
		bpm_init <= 1'b0;
		@(posedge clk);
		@(negedge clk);
		check_value("bpm_size", bpm_size, 0);
		load_table(TABLE_WORDS);
		@(negedge clk);
		check_value("bpm_size", bpm_size, TABLE_WORDS);

		for (int r = 0; r < ROWS; r++)
			run_row(rows[r]);

		$display("All tests passed!");
		$finish;
	end

endmodule

`default_nettype wire

// ==== bench/motor_model.sv ====
`default_nettype none

module motor_model #(
	parameter logic UP_DIR = 1'b1
) (
	input  wire                        clk,
	input  wire                        resetn,
	input  wire                        start,
	input  wire fscpu_pkg::motor_cmd_t cmd,
	input  wire                        load,
	input  wire fscpu_pkg::img_pos_t   load_pos,
	input  wire                        valid_set,
	output logic                       state,
	output fscpu_pkg::img_pos_t        edge_pos,
	output logic                       valid
);
	import fscpu_pkg::*;

	localparam logic [31:0] SEED = 32'haa67_2a99;

	logic [31:0] lfsr;
	logic [3:0]  busy_cnt;
	motor_cmd_t  held;

	// fibonacci, taps 32 22 2 1
	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	assign valid = valid_set;

	always @(posedge clk) begin
		logic [2:0] extra;
		if (!resetn) begin
			lfsr = SEED;
			state    <= 1'b0;
			busy_cnt <= '0;
			edge_pos <= '0;
		end else begin
			if (load)
				edge_pos <= load_pos;
			if (start) begin
				extra = '0;
				// one lfsr step per random bit
				for (int i = 0; i < 3; i++) begin
					lfsr = lfsr_step(lfsr);
					extra = {extra[1:0], lfsr[0]};
				end
				busy_cnt <= 4'd3 + {1'b0, extra};
				held     <= cmd;
				state    <= 1'b1;
			end else if (state) begin
				if (busy_cnt == 4'd1) begin
					state <= 1'b0;
					if (held.dir == UP_DIR)
						edge_pos <= edge_pos + img_pos_t'(held.step);
					else
						edge_pos <= edge_pos - img_pos_t'(held.step);
				end
				busy_cnt <= busy_cnt - 4'd1;
			end
		end
	end

endmodule

`default_nettype wire

// ==== source/fscpu.sv ====
`default_nettype none

module fscpu (
	input  wire                         clk,
	input  wire                         resetn,
	input  wire                         bpm_init,
	input  wire                         bpm_wr_en,
	input  wire fscpu_pkg::step_t       bpm_data,
	output wire [fscpu_pkg::IMG_WW:0]   bpm_size,
	input  wire                         req_en,
	input  wire fscpu_pkg::cmd_t        req_cmd,
	input  wire [127:0]                 req_param,
	output wire                         req_done,
	output wire fscpu_pkg::err_t        req_err,
	input  wire                         ana_done,
	input  wire                         lft_valid,
	input  wire fscpu_pkg::img_pos_t    lft_edge,
	input  wire                         rt_valid,
	input  wire fscpu_pkg::img_pos_t    rt_edge,
	output wire                         ml_start,
	output wire fscpu_pkg::motor_cmd_t  ml_cmd,
	input  wire                         ml_state,
	output wire                         mr_start,
	output wire fscpu_pkg::motor_cmd_t  mr_cmd,
	input  wire                         mr_state
);
	import fscpu_pkg::*;

	wire dev_bmp_t   dev_en;
	wire dev_bmp_t   exe_done;
	wire dev_bmp_t   no_edge;
	wire motor_req_t mreq;
	wire step_t      img_delay;
	wire step_t      bpm_q_a;
	wire step_t      bpm_q_b;
	wire img_pos_t   bpm_addr_a;
	wire img_pos_t   bpm_addr_b;
	wire             imm_done;
	wire             bad_cmd;
	wire             dev_release;

	cmd_decode decode (
		.clk(clk), .resetn(resetn),
		.req_en(req_en), .req_cmd(req_cmd), .req_param(req_param),
		.dev_release(dev_release),
		.dev_en(dev_en), .mreq(mreq), .img_delay(img_delay),
		.imm_done(imm_done), .bad_cmd(bad_cmd)
	);

	step_table bpm_table (
		.clk(clk),
		.wr_resetn(bpm_init), .wr_en(bpm_wr_en), .wr_data(bpm_data), .size(bpm_size),
		.addr_a(bpm_addr_a), .q_a(bpm_q_a),
		.addr_b(bpm_addr_b), .q_b(bpm_q_b)
	);

	// each controller is held in reset by its own enable bit
	push_motor_ctl #(.L2R(1)) lft_motor_ctl (
		.clk(clk), .resetn(dev_en[DEV_LFT]),
		.mreq(mreq), .img_delay(img_delay),
		.img_pulse(ana_done), .img_valid(lft_valid), .img_pos(lft_edge),
		.rd_addr(bpm_addr_a), .rd_data(bpm_q_a),
		.m_start(ml_start), .m_cmd(ml_cmd), .m_state(ml_state),
		.exe_done(exe_done[DEV_LFT]), .no_edge(no_edge[DEV_LFT])
	);

	push_motor_ctl #(.L2R(0)) rt_motor_ctl (
		.clk(clk), .resetn(dev_en[DEV_RT]),
		.mreq(mreq), .img_delay(img_delay),
		.img_pulse(ana_done), .img_valid(rt_valid), .img_pos(rt_edge),
		.rd_addr(bpm_addr_b), .rd_data(bpm_q_b),
		.m_start(mr_start), .m_cmd(mr_cmd), .m_state(mr_state),
		.exe_done(exe_done[DEV_RT]), .no_edge(no_edge[DEV_RT])
	);

	req_status status (
		.clk(clk), .resetn(resetn), .req_en(req_en),
		.dev_en(dev_en), .exe_done(exe_done),
		.imm_done(imm_done), .bad_cmd(bad_cmd), .no_edge(no_edge),
		.dev_release(dev_release), .req_done(req_done), .req_err(req_err)
	);

endmodule

`default_nettype wire

// ==== source/req_status.sv ====
`default_nettype none

module req_status (
	input  wire                      clk,
	input  wire                      resetn,
	input  wire                      req_en,
	input  wire fscpu_pkg::dev_bmp_t dev_en,
	input  wire fscpu_pkg::dev_bmp_t exe_done,
	input  wire                      imm_done,
	input  wire                      bad_cmd,
	input  wire fscpu_pkg::dev_bmp_t no_edge,
	output logic                     dev_release,
	output logic                     req_done,
	output fscpu_pkg::err_t          req_err
);
	import fscpu_pkg::*;

	logic all_done;
	logic finish;
	err_t err_set;

	assign all_done = (dev_en != '0) && ((exe_done & dev_en) == dev_en);
	// dev_en is still high the cycle after release, so skip that one
	assign finish = (all_done && !dev_release) || imm_done;

	always_comb begin
		err_set = '0;
		err_set[ERR_BAD_CMD]   = bad_cmd;
		err_set[ERR_NO_EDGE_L] = no_edge[DEV_LFT];
		err_set[ERR_NO_EDGE_R] = no_edge[DEV_RT];
	end

	always_ff @(posedge clk) begin
		if (!resetn) begin
			dev_release <= 1'b0;
			req_done    <= 1'b0;
			req_err     <= '0;
		end else begin
			dev_release <= finish;
			if (req_en) begin
				req_done <= 1'b0;
				req_err  <= '0;
			end else begin
				if (finish)
					req_done <= 1'b1;
				req_err <= req_err | err_set;
			end
		end
	end

endmodule

`default_nettype wire

// ==== source/push_motor_ctl.sv ====
`default_nettype none

module push_motor_ctl #(
	parameter int L2R = 0
) (
	input  wire                        clk,
	input  wire                        resetn,
	input  wire fscpu_pkg::motor_req_t mreq,
	input  wire fscpu_pkg::step_t      img_delay,
	input  wire                        img_pulse,
	input  wire                        img_valid,
	input  wire fscpu_pkg::img_pos_t   img_pos,
	output fscpu_pkg::img_pos_t        rd_addr,
	input  wire fscpu_pkg::step_t      rd_data,
	output logic                       m_start,
	output fscpu_pkg::motor_cmd_t      m_cmd,
	input  wire                        m_state,
	output logic                       exe_done,
	output logic                       no_edge
);
	import fscpu_pkg::*;

	typedef enum logic [2:0] {
		IDLE,
		WAIT_IMG,
		DELAY,
		LOOKUP,
		START,
		MOVE,
		DONE
	} state_t;

	// left motor runs mirrored to the right one
	localparam logic DIR_INV = (L2R != 0);

	state_t          state;
	step_t           delay_cnt;
	logic            seen_busy;
	logic            img_dir;
	logic [IMG_WW:0] diff;
	img_pos_t        abs_err;

	// target minus edge, msb is the sign
	assign diff    = {1'b0, mreq.img_dst} - {1'b0, img_pos};
	assign abs_err = diff[IMG_WW] ? img_pos_t'(-diff) : diff[IMG_WW-1:0];

	assign exe_done = (state == DONE);

	always_ff @(posedge clk) begin
		if (!resetn) begin
			state     <= IDLE;
			delay_cnt <= '0;
			seen_busy <= 1'b0;
			m_start   <= 1'b0;
			no_edge   <= 1'b0;
		end else begin
			m_start <= 1'b0;
			no_edge <= 1'b0;
			case (state)
			IDLE: begin
				state <= mreq.dep_img ? WAIT_IMG : START;
			end
			WAIT_IMG: begin
				if (img_pulse) begin
					delay_cnt <= '0;
					state     <= DELAY;
				end
			end
			DELAY: begin
				if (delay_cnt != img_delay) begin
					delay_cnt <= delay_cnt + 1'b1;
				end else if (!img_valid) begin
					no_edge <= 1'b1;
					state   <= DONE;
				end else if (abs_err <= mreq.img_tol) begin
					state <= DONE;
				end else begin
					state <= LOOKUP;
				end
			end
			// table read in flight
			LOOKUP: state <= START;
			START: begin
				m_start   <= 1'b1;
				seen_busy <= 1'b0;
				state     <= MOVE;
			end
			MOVE: begin
				if (m_state)
					seen_busy <= 1'b1;
				else if (seen_busy)
					state <= mreq.dep_img ? WAIT_IMG : DONE;
			end
			// held here until dev_en drops
			DONE: state <= DONE;
			default: state <= IDLE;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (state == DELAY) begin
			rd_addr <= abs_err;
			img_dir <= diff[IMG_WW] ^ DIR_INV;
		end
		if (state == START) begin
			m_cmd.speed <= mreq.speed;
			m_cmd.step  <= mreq.dep_img ? rd_data : mreq.step;
			m_cmd.dir   <= mreq.dep_img ? img_dir : mreq.dir_back;
		end
	end

endmodule

`default_nettype wire

// ==== source/step_table.sv ====
`default_nettype none

module step_table (
	input  wire                        clk,
	input  wire                        wr_resetn,
	input  wire                        wr_en,
	input  wire fscpu_pkg::step_t      wr_data,
	output logic [fscpu_pkg::IMG_WW:0] size,
	input  wire fscpu_pkg::img_pos_t   addr_a,
	output fscpu_pkg::step_t           q_a,
	input  wire fscpu_pkg::img_pos_t   addr_b,
	output fscpu_pkg::step_t           q_b
);
	import fscpu_pkg::*;

	localparam int DEPTH = 2 ** IMG_WW;

	step_t           mem [DEPTH];
	logic [IMG_WW:0] wr_ptr;
	logic            full;

	assign full = wr_ptr[IMG_WW];
	assign size = wr_ptr;

	// append only, pointer held at zero while init is low
	always_ff @(posedge clk) begin
		if (!wr_resetn)
			wr_ptr <= '0;
		else if (wr_en && !full)
			wr_ptr <= wr_ptr + 1'b1;
	end

	always_ff @(posedge clk) begin
		if (wr_resetn && wr_en && !full)
			mem[wr_ptr[IMG_WW-1:0]] <= wr_data;
	end

	// one read port per motor
	always_ff @(posedge clk) begin
		q_a <= mem[addr_a];
		q_b <= mem[addr_b];
	end

endmodule

`default_nettype wire

// ==== source/cmd_decode.sv ====
`default_nettype none

module cmd_decode (
	input  wire                   clk,
	input  wire                   resetn,
	input  wire                   req_en,
	input  wire fscpu_pkg::cmd_t  req_cmd,
	input  wire [127:0]           req_param,
	input  wire                   dev_release,
	output fscpu_pkg::dev_bmp_t   dev_en,
	output fscpu_pkg::motor_req_t mreq,
	output fscpu_pkg::step_t      img_delay,
	output logic                  imm_done,
	output logic                  bad_cmd
);
	import fscpu_pkg::*;

	logic [31:0] par0;
	logic [31:0] par1;
	logic [31:0] par2;
	logic [31:0] par3;
	dev_bmp_t    dev_sel;
	logic        is_motor;

	assign par0 = req_param[31:0];
	assign par1 = req_param[63:32];
	assign par2 = req_param[95:64];
	assign par3 = req_param[127:96];

	always_comb begin
		dev_sel = '0;
		dev_sel[DEV_LFT] = (req_cmd == CMD_LFT) || (req_cmd == CMD_BOTH);
		dev_sel[DEV_RT]  = (req_cmd == CMD_RT) || (req_cmd == CMD_BOTH);
	end

	assign is_motor = (dev_sel != '0);

	always_ff @(posedge clk) begin
		if (!resetn) begin
			dev_en    <= '0;
			img_delay <= '0;
			imm_done  <= 1'b0;
			bad_cmd   <= 1'b0;
		end else begin
			// config and unknown codes finish without any device
			imm_done <= req_en && !is_motor;
			bad_cmd  <= req_en && !is_motor && (req_cmd != CMD_CFG);
			if (req_en)
				dev_en <= dev_sel;
			else if (dev_release)
				dev_en <= '0;
			if (req_en && (req_cmd == CMD_CFG))
				img_delay <= par0;
		end
	end

	// request fields stay put for the whole command
	always_ff @(posedge clk) begin
		if (req_en && is_motor) begin
			mreq.dir_back <= par0[1];
			mreq.dep_img  <= par0[2];
			mreq.img_dst  <= par1[IMG_WW-1:0];
			mreq.img_tol  <= par1[16 +: IMG_WW];
			mreq.speed    <= par2;
			mreq.step     <= par3;
		end
	end

endmodule

`default_nettype wire

// ==== source/fscpu_pkg.sv ====
`default_nettype none

package fscpu_pkg;

	localparam int IMG_WW  = 12;
	localparam int SPEED_W = 32;
	localparam int STEP_W  = 32;
	localparam int DEV_N   = 2;

	// device bitmap positions
	localparam int DEV_LFT = 0;
	localparam int DEV_RT  = 1;

	typedef logic [IMG_WW-1:0]  img_pos_t;
	typedef logic [SPEED_W-1:0] speed_t;
	typedef logic [STEP_W-1:0]  step_t;
	typedef logic [31:0]        cmd_t;
	typedef logic [DEV_N-1:0]   dev_bmp_t;
	typedef logic [31:0]        err_t;

	localparam cmd_t CMD_CFG  = 32'd0;
	localparam cmd_t CMD_LFT  = 32'd1;
	localparam cmd_t CMD_RT   = 32'd2;
	localparam cmd_t CMD_BOTH = 32'd3;

	// bit positions in req_err
	localparam int ERR_BAD_CMD   = 0;
	localparam int ERR_NO_EDGE_L = 1;
	localparam int ERR_NO_EDGE_R = 2;

	typedef struct packed {
		logic     dir_back;
		logic     dep_img;
		img_pos_t img_dst;
		img_pos_t img_tol;
		speed_t   speed;
		step_t    step;
	} motor_req_t;

	typedef struct packed {
		speed_t speed;
		step_t  step;
		logic   dir;
	} motor_cmd_t;

endpackage

`default_nettype wire
